/* event_wb_if.sv */
//--------------------------------------------------------------------------
// wishbone classic read bus between the replay sequencer and the event log
//--------------------------------------------------------------------------
`default_nettype none

interface event_wb_if #(
    parameter int ADR_W = 4
) (
    input logic i_AUD_DACLRCK,
    input logic i_rst_n
);
    import tone_pkg::*;

    logic             cyc;
    logic             stb;
    logic [ADR_W-1:0] adr;                        // log entry index
    log_entry_t       dat_r;                      // valid while ack is high
    logic             ack;                        // single cycle

    modport master (
        input  i_AUD_DACLRCK, i_rst_n, dat_r, ack,
        output cyc, stb, adr
    );

    modport slave (
        input  i_AUD_DACLRCK, i_rst_n, cyc, stb, adr,
        output dat_r, ack
    );

endinterface

`default_nettype wire

/* note_log.sv */
//--------------------------------------------------------------------------
// event log: appends {voice, time} per live key, read back over wishbone
//--------------------------------------------------------------------------
`default_nettype none

module note_log #(
    parameter int LOG_DEPTH = 16
) (
    input  logic                           i_AUD_DACLRCK,
    input  logic                           i_rst_n,
    input  logic                           i_rec_valid,
    input  tone_pkg::voice_t               i_rec_voice,
    input  tone_pkg::stamp_t               i_time,
    event_wb_if.slave                      wb,
    output logic [$clog2(LOG_DEPTH+1)-1:0] o_count,
    output logic                           o_full
);
    import tone_pkg::*;

    localparam int ADR_W = $clog2(LOG_DEPTH);
    localparam int CNT_W = $clog2(LOG_DEPTH + 1);

    log_entry_t mem [LOG_DEPTH];
    logic       rec_en;
    logic       rd_req;

    assign o_full = (o_count == CNT_W'(LOG_DEPTH));
    assign rec_en = i_rec_valid && !o_full;       // events past full are dropped
    assign rd_req = wb.cyc && wb.stb && !wb.ack;  // new strobe, not yet acked

    // ----------------------------------------------------------------------
    // record side
    // ----------------------------------------------------------------------
    always_ff @(posedge i_AUD_DACLRCK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_count <= '0;
        end else if (rec_en) begin
            o_count <= o_count + CNT_W'(1);
        end
    end

    always_ff @(posedge i_AUD_DACLRCK) begin
        if (rec_en) begin
            mem[o_count[ADR_W-1:0]] <= '{voice: i_rec_voice, stamp: i_time};
        end
    end

    // ----------------------------------------------------------------------
    // wishbone read side
    // ----------------------------------------------------------------------
    // ack lands the cycle after the strobe is seen, and only once per
    // strobe because the master needs a cycle to drop stb
    always_ff @(posedge i_AUD_DACLRCK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wb.ack <= 1'b0;
        end else begin
            wb.ack <= rd_req;
        end
    end

    always_ff @(posedge i_AUD_DACLRCK) begin
        if (rd_req) begin
            wb.dat_r <= mem[wb.adr];              // lines up with ack
        end
    end

endmodule

`default_nettype wire

/* project.f */
tone_pkg.sv
event_wb_if.sv
sampler_ctrl.sv
note_log.sv
replay_seq.sv
tone_voices.sv
tone_sampler_top.sv
tone_sampler_props.sv
tb_tone_sampler.sv

/* replay_seq.sv */
//--------------------------------------------------------------------------
// replay sequencer: fetches log entries over wishbone and fires each
// voice toggle once the sample timer reaches the entry's stamp
//--------------------------------------------------------------------------
`default_nettype none

module replay_seq #(
    parameter int LOG_DEPTH = 16
) (
    input  logic                           i_AUD_DACLRCK,
    input  logic                           i_rst_n,
    input  tone_pkg::ctrl_state_e          i_state,
    input  tone_pkg::stamp_t               i_time,
    input  logic                           i_replay,
    input  logic                           i_replay_start,
    input  logic [$clog2(LOG_DEPTH+1)-1:0] i_count,
    event_wb_if.master                     wb,
    output logic                           o_toggle,
    output tone_pkg::voice_t               o_toggle_voice
);
    import tone_pkg::*;

    localparam int ADR_W = $clog2(LOG_DEPTH);
    localparam int CNT_W = $clog2(LOG_DEPTH + 1);

    typedef enum logic [1:0] {
        FETCH,
        WAIT_ACK,
        HOLD
    } seq_state_e;

    seq_state_e       seq_r;
    logic [CNT_W-1:0] idx_r;                      // next entry to play
    log_entry_t       entry_r;                    // entry waiting for its time

    assign wb.adr         = idx_r[ADR_W-1:0];
    assign o_toggle_voice = entry_r.voice;

    // due entry; restart wins over a stale entry
    assign o_toggle = (seq_r == HOLD) && i_replay && !i_replay_start
                   && (i_state == S_PLAY) && (i_time >= entry_r.stamp);

    // ----------------------------------------------------------------------
    // fetch / hold FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge i_AUD_DACLRCK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seq_r  <= FETCH;
            idx_r  <= '0;
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
        end else if (i_replay_start) begin
            seq_r  <= FETCH;                      // walk again from entry 0
            idx_r  <= '0;
            wb.cyc <= 1'b0;
            wb.stb <= 1'b0;
        end else begin
            case (seq_r)
                FETCH: begin
                    if (i_replay && (idx_r < i_count)) begin
                        wb.cyc <= 1'b1;
                        wb.stb <= 1'b1;
                        seq_r  <= WAIT_ACK;
                    end
                end
                WAIT_ACK: begin
                    if (wb.ack) begin
                        wb.cyc <= 1'b0;
                        wb.stb <= 1'b0;
                        seq_r  <= HOLD;
                    end
                end
                HOLD: begin
                    if (o_toggle) begin
                        idx_r <= idx_r + CNT_W'(1);
                        seq_r <= FETCH;
                    end
                end
                default: begin
                    seq_r <= FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge i_AUD_DACLRCK) begin
        if (seq_r == WAIT_ACK && wb.ack) begin
            entry_r <= wb.dat_r;
        end
    end

endmodule

`default_nettype wire

/* sampler_ctrl.sv */
//--------------------------------------------------------------------------
// sampler control: idle/init/play/pause FSM, sample timer, replay start
//--------------------------------------------------------------------------
`default_nettype none

module sampler_ctrl (
    input  logic                  i_AUD_DACLRCK,
    input  logic                  i_rst_n,
    input  logic                  i_init_done,
    input  logic                  i_play_pause,
    input  logic                  i_replay,
    output tone_pkg::ctrl_state_e o_state,
    output tone_pkg::stamp_t      o_time,
    output logic                  o_replay_start
);
    import tone_pkg::*;

    ctrl_state_e state_nxt;
    stamp_t      time_nxt;
    logic        replay_q;                        // last cycle's replay level

    assign o_replay_start = i_replay & ~replay_q; // rising edge of replay

    // ----------------------------------------------------------------------
    // next state
    // ----------------------------------------------------------------------
    always_comb begin
        state_nxt = o_state;
        case (o_state)
            S_IDLE: begin
                state_nxt = S_INIT;
            end
            S_INIT: begin
                if (i_init_done) begin
                    state_nxt = S_PLAY;
                end
            end
            S_PLAY: begin
                if (i_play_pause) begin
                    state_nxt = S_PAUSE;
                end
            end
            S_PAUSE: begin
                if (i_play_pause) begin
                    state_nxt = S_PLAY;
                end
            end
            default: begin
                state_nxt = S_IDLE;
            end
        endcase
    end

    // timer runs in play, freezes in pause, zero elsewhere
    always_comb begin
        if (o_replay_start) begin
            time_nxt = '0;                        // replay restarts the clock
        end else if (o_state == S_PLAY) begin
            time_nxt = o_time + stamp_t'(1);
        end else if (o_state == S_PAUSE) begin
            time_nxt = o_time;
        end else begin
            time_nxt = '0;
        end
    end

    always_ff @(posedge i_AUD_DACLRCK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_state  <= S_IDLE;
            o_time   <= '0;
            replay_q <= 1'b0;
        end else begin
            o_state  <= state_nxt;
            o_time   <= time_nxt;
            replay_q <= i_replay;
        end
    end

endmodule

`default_nettype wire

/* tb_tone_sampler.sv */
//--------------------------------------------------------------------------
// tone sampler testbench: start-up, live play, pause, logging and replay
// against a cycle model of the sampler
//--------------------------------------------------------------------------
`default_nettype none

module tb_tone_sampler;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int LOG_DEPTH    = 16;
    localparam int AMP          = 600;
    localparam int RESET_CYCLES = 16;
    localparam int LIVE_KEYS    = 10;
    localparam int LOG_KEYS     = 12;
    localparam int ST_IDLE      = 0;
    localparam int ST_INIT      = 1;
    localparam int ST_PLAY      = 2;
    localparam int ST_PAUSE     = 3;
    // key presses take at most 13 cycles; replay runs about as long as recording
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * (30 + 13 * LIVE_KEYS + 80
                                  + 13 * LOG_KEYS) + 140;
    localparam int CYCLE_LIMIT  = 3 * TEST_CYCLES;
    localparam int VOICE_HALF [8] = '{122, 109, 97, 92, 82, 73, 65, 61};

    logic        i_AUD_DACLRCK = 1'b0;
    logic        i_rst_n;
    logic        i_init_done;
    logic        i_play_pause;
    logic        i_replay;
    logic [7:0]  i_key;
    logic [15:0] o_dac_sample;
    logic [3:0]  o_state_led;
    logic [4:0]  o_event_count;
    logic        o_log_full;

    // reference model
    int          m_state;
    int          m_time;
    int          m_sample;
    int          m_count;
    logic        m_replay_q;
    logic [7:0]  m_en;
    int          m_log_voice [LOG_DEPTH];
    int          m_log_stamp [LOG_DEPTH];

    string       cur_test;
    int          err_cnt = 0;
    int          err_at_start;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycle_cnt = 0;
    int unsigned rnd = 40742;
    logic        replaying = 1'b0;
    int          rp_idx = 0;
    logic [7:0]  prev_en = '0;
    int          seen_time = 0;
    logic [7:0]  final_en;

    tone_sampler_top #(.LOG_DEPTH(LOG_DEPTH), .VOICE_AMPLITUDE(AMP)) DUT (
        .i_AUD_DACLRCK (i_AUD_DACLRCK),
        .i_rst_n       (i_rst_n),
        .i_init_done   (i_init_done),
        .i_play_pause  (i_play_pause),
        .i_replay      (i_replay),
        .i_key         (i_key),
        .o_dac_sample  (o_dac_sample),
        .o_state_led   (o_state_led),
        .o_event_count (o_event_count),
        .o_log_full    (o_log_full)
    );

    always #4 i_AUD_DACLRCK = ~i_AUD_DACLRCK;

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int model_mix(input int t, input logic [7:0] en);
        int total;
        total = 0;
        for (int v = 0; v < 8; v++) begin
            if (en[v] && ((t / VOICE_HALF[v]) % 2 == 1)) begin
                total += AMP;
            end
        end
        return total;
    endfunction

    function automatic int key_index(input logic [7:0] k);
        for (int v = 0; v < 8; v++) begin
            if (k[v]) begin
                return v;
            end
        end
        return 0;
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("error %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
            err_cnt++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_at_start = err_cnt;
    endtask

    task automatic report_test();
        tests_run++;
        if (err_cnt == err_at_start) begin
            $display("%s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", cur_test, err_cnt - err_at_start);
        end
    endtask

    task automatic press_key(input int v, input int gap);
        @(posedge i_AUD_DACLRCK);
        i_key <= 8'(1 << v);
        @(posedge i_AUD_DACLRCK);
        i_key <= '0;
        repeat (gap) @(posedge i_AUD_DACLRCK);
    endtask

    task automatic pulse_play_pause();
        @(posedge i_AUD_DACLRCK);
        i_play_pause <= 1'b1;
        @(posedge i_AUD_DACLRCK);
        i_play_pause <= 1'b0;
    endtask

    task automatic random_keys(input int n);
        for (int i = 0; i < n; i++) begin
            rnd = lcg_step(rnd);
            press_key((rnd >> 16) % 8, 4 + (rnd >> 8) % 8);
        end
    endtask

    task automatic check_toggle(input logic [7:0] diff);
        if (rp_idx >= m_count) begin
            $display("error %s: enables changed after the whole log was replayed", cur_test);
            err_cnt++;
        end else begin
            compare_value("toggled voice", 1 << m_log_voice[rp_idx], diff);
            assert (seen_time >= m_log_stamp[rp_idx]) else begin
                $display("error %s toggle time: expected >= %0d actual %0d",
                         cur_test, m_log_stamp[rp_idx], seen_time);
                err_cnt++;
            end
            rp_idx++;
        end
    endtask

    // ----------------------------------------------------------------------
    // cycle model, reads the inputs the DUT sees at this edge
    // ----------------------------------------------------------------------
    always @(posedge i_AUD_DACLRCK) begin
        if (!i_rst_n) begin
            m_state    <= ST_IDLE;
            m_time     <= 0;
            m_sample   <= 0;
            m_count    <= 0;
            m_replay_q <= 1'b0;
            m_en       <= '0;
        end else begin
            m_sample   <= (m_state == ST_PLAY) ? model_mix(m_time, m_en) : 0;
            m_replay_q <= i_replay;
            if (m_state == ST_PLAY && !i_replay && i_key != '0) begin
                m_en <= m_en ^ i_key;
                if (m_count < LOG_DEPTH) begin
                    m_log_voice[m_count] <= key_index(i_key);
                    m_log_stamp[m_count] <= m_time;
                    m_count              <= m_count + 1;
                end
            end
            if (i_replay && !m_replay_q) begin
                m_time <= 0;                      // replay restarts the timer
            end else if (m_state == ST_PLAY) begin
                m_time <= m_time + 1;
            end else if (m_state != ST_PAUSE) begin
                m_time <= 0;
            end
            if (m_state == ST_IDLE) begin
                m_state <= ST_INIT;
            end else if (m_state == ST_INIT) begin
                if (i_init_done) begin
                    m_state <= ST_PLAY;
                end
            end else if (i_play_pause) begin
                m_state <= (m_state == ST_PLAY) ? ST_PAUSE : ST_PLAY;
            end
        end
    end

    // outputs are compared mid-cycle
    always @(negedge i_AUD_DACLRCK) begin
        if (i_rst_n) begin
            compare_value("state led", 1 << m_state, o_state_led);
            compare_value("event count", m_count, o_event_count);
            compare_value("log full", m_count == LOG_DEPTH, o_log_full);
            if (!replaying) begin
                compare_value("dac sample", m_sample, o_dac_sample);
                compare_value("enables", m_en, DUT.voice_en);
            end else if (DUT.voice_en != prev_en) begin
                check_toggle(DUT.voice_en ^ prev_en);
            end
        end
        prev_en = DUT.voice_en;
        seen_time = m_time;                       // timer of the cycle now ending
    end

    always @(posedge i_AUD_DACLRCK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles without finishing", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------------------
    initial begin
        i_rst_n      = 1'b0;
        i_init_done  = 1'b0;
        i_play_pause = 1'b0;
        i_replay     = 1'b0;
        i_key        = '0;

        start_test("startup");
        repeat (RESET_CYCLES) @(posedge i_AUD_DACLRCK);
        i_rst_n <= 1'b1;
        repeat (4) @(posedge i_AUD_DACLRCK);
        i_init_done <= 1'b1;
        @(negedge i_AUD_DACLRCK);
        compare_value("led before init seen", 4'b0010, o_state_led);
        compare_value("sample before play", 0, o_dac_sample);
        @(negedge i_AUD_DACLRCK);
        compare_value("led after init seen", 4'b0100, o_state_led);
        report_test();

        start_test("live play");
        random_keys(LIVE_KEYS);
        report_test();

        start_test("pause");
        pulse_play_pause();
        repeat (20) @(posedge i_AUD_DACLRCK);
        compare_value("paused led", 4'b1000, o_state_led);
        press_key(3, 6);                          // ignored while paused
        pulse_play_pause();
        repeat (40) @(posedge i_AUD_DACLRCK);
        report_test();

        start_test("logging");
        random_keys(LOG_KEYS);
        compare_value("full flag", 1, o_log_full);
        compare_value("final count", LOG_DEPTH, o_event_count);
        report_test();

        start_test("replay");
        for (int v = 0; v < 8; v++) begin
            if (m_en[v]) begin
                press_key(v, 4);
            end
        end
        @(negedge i_AUD_DACLRCK);
        compare_value("enables cleared", 0, DUT.voice_en);
        final_en = '0;
        for (int k = 0; k < m_count; k++) begin
            final_en ^= 8'(1 << m_log_voice[k]);
        end
        @(posedge i_AUD_DACLRCK);
        i_replay <= 1'b1;
        replaying = 1'b1;
        while (rp_idx < m_count) @(posedge i_AUD_DACLRCK);
        repeat (20) @(posedge i_AUD_DACLRCK);
        compare_value("final enables", final_en, DUT.voice_en);
        report_test();

        if (DUT.u_props.fail_count != 0) begin
            $display("bound assertions failed %0d times", DUT.u_props.fail_count);
            err_cnt += DUT.u_props.fail_count;
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tone_pkg.sv */
//--------------------------------------------------------------------------
// tone sampler shared definitions: control states, sample-time types,
// event log entry layout and the voice half-period table
//--------------------------------------------------------------------------
`default_nettype none

package tone_pkg;

    // ---------------------------------------------------------------------
    // voices
    // ---------------------------------------------------------------------
    localparam int NUM_VOICES = 8;

    typedef logic [2:0] voice_t;                  // voice index 0..7

    // half-period in samples, voice 0 is the lowest pitch
    localparam logic [7:0] VOICE_HALF_PERIOD [NUM_VOICES] = '{
        8'd122, 8'd109, 8'd97, 8'd92, 8'd82, 8'd73, 8'd65, 8'd61
    };

    // ---------------------------------------------------------------------
    // time and samples
    // ---------------------------------------------------------------------
    localparam int TIME_W   = 20;
    localparam int SAMPLE_W = 16;

    typedef logic [TIME_W-1:0]   stamp_t;         // one count per dac frame
    typedef logic [SAMPLE_W-1:0] sample_t;

    // one recorded key toggle
    typedef struct packed {
        voice_t voice;
        stamp_t stamp;
    } log_entry_t;

    // ---------------------------------------------------------------------
    // control FSM
    // ---------------------------------------------------------------------
    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_INIT  = 2'd1,                           // codec setup in progress
        S_PLAY  = 2'd2,
        S_PAUSE = 2'd3
    } ctrl_state_e;

endpackage

`default_nettype wire

/* tone_sampler_props.sv */
//--------------------------------------------------------------------------
// tone sampler checks: led encoding, silence outside play, wishbone ack
// ordering and log full consistency
//--------------------------------------------------------------------------
`default_nettype none

module tone_sampler_props #(
    parameter int LOG_DEPTH = 16
) (
    input logic                           i_AUD_DACLRCK,
    input logic                           i_rst_n,
    input tone_pkg::ctrl_state_e          i_state,
    input logic [3:0]                     i_state_led,
    input logic [15:0]                    i_dac_sample,
    input logic                           i_stb,
    input logic                           i_ack,
    input logic                           i_log_full,
    input logic [$clog2(LOG_DEPTH+1)-1:0] i_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import tone_pkg::*;

    int fail_count = 0;                           // read by the testbench

    a_led_onehot: assert property (@(posedge i_AUD_DACLRCK) disable iff (!i_rst_n)
        $onehot(i_state_led))
        else begin
            fail_count = fail_count + 1;
            $error("state led is not one-hot");
        end

    // sample register lags the state by one cycle
    a_silent: assert property (@(posedge i_AUD_DACLRCK) disable iff (!i_rst_n)
        (i_state != S_PLAY) |=> (i_dac_sample == '0))
        else begin
            fail_count = fail_count + 1;
            $error("dac sample not zero outside play");
        end

    a_ack_after_stb: assert property (@(posedge i_AUD_DACLRCK) disable iff (!i_rst_n)
        i_ack |-> $past(i_stb))
        else begin
            fail_count = fail_count + 1;
            $error("wishbone ack without a strobe");
        end

    // once full the log stays full and the count holds at depth
    a_full_count: assert property (@(posedge i_AUD_DACLRCK) disable iff (!i_rst_n)
        i_log_full |-> (i_count == LOG_DEPTH) ##1 (i_log_full && $stable(i_count)))
        else begin
            fail_count = fail_count + 1;
            $error("log full with count off depth or not held");
        end

endmodule

bind tone_sampler_top tone_sampler_props #(.LOG_DEPTH(LOG_DEPTH)) u_props (
    .i_AUD_DACLRCK (i_AUD_DACLRCK),
    .i_rst_n       (i_rst_n),
    .i_state       (state),
    .i_state_led   (o_state_led),
    .i_dac_sample  (o_dac_sample),
    .i_stb         (wb_bus.stb),
    .i_ack         (wb_bus.ack),
    .i_log_full    (o_log_full),
    .i_count       (o_event_count)
);

`default_nettype wire

/* tone_sampler_top.sv */
//--------------------------------------------------------------------------
// tone sampler top: control, event log, replay and voices on the dac clock
//--------------------------------------------------------------------------
`default_nettype none

module tone_sampler_top #(
    parameter int LOG_DEPTH       = 16,
    parameter int VOICE_AMPLITUDE = 600
) (
    input  logic                           i_AUD_DACLRCK,
    input  logic                           i_rst_n,
    input  logic                           i_init_done,
    input  logic                           i_play_pause,
    input  logic                           i_replay,
    input  logic [7:0]                     i_key,
    output logic [15:0]                    o_dac_sample,
    output logic [3:0]                     o_state_led,
    output logic [$clog2(LOG_DEPTH+1)-1:0] o_event_count,
    output logic                           o_log_full
);
    import tone_pkg::*;

    ctrl_state_e           state;
    stamp_t                time_now;
    logic                  replay_start;
    logic                  live_en;
    logic [NUM_VOICES-1:0] live_key;
    logic                  rec_valid;
    voice_t                rec_voice;
    logic                  toggle;
    voice_t                toggle_voice;
    logic [NUM_VOICES-1:0] voice_en;              // current enables, debug view

    event_wb_if #(.ADR_W($clog2(LOG_DEPTH))) wb_bus (
        .i_AUD_DACLRCK (i_AUD_DACLRCK),
        .i_rst_n       (i_rst_n)
    );

    // ----------------------------------------------------------------------
    // live keys count only while playing by hand
    // ----------------------------------------------------------------------
    assign live_en   = (state == S_PLAY) && !i_replay;
    assign live_key  = i_key & {NUM_VOICES{live_en}};
    assign rec_valid = |live_key;

    always_comb begin
        rec_voice = '0;
        for (int v = NUM_VOICES - 1; v >= 0; v--) begin
            if (live_key[v]) begin
                rec_voice = voice_t'(v);          // lowest key wins
            end
        end
    end

    assign o_state_led = 4'b0001 << state;        // idle, init, play, pause

    sampler_ctrl u_ctrl (
        .i_AUD_DACLRCK  (i_AUD_DACLRCK),
        .i_rst_n        (i_rst_n),
        .i_init_done    (i_init_done),
        .i_play_pause   (i_play_pause),
        .i_replay       (i_replay),
        .o_state        (state),
        .o_time         (time_now),
        .o_replay_start (replay_start)
    );

    note_log #(.LOG_DEPTH(LOG_DEPTH)) u_log (
        .i_AUD_DACLRCK (i_AUD_DACLRCK),
        .i_rst_n       (i_rst_n),
        .i_rec_valid   (rec_valid),
        .i_rec_voice   (rec_voice),
        .i_time        (time_now),
        .wb            (wb_bus.slave),
        .o_count       (o_event_count),
        .o_full        (o_log_full)
    );

    replay_seq #(.LOG_DEPTH(LOG_DEPTH)) u_seq (
        .i_AUD_DACLRCK  (i_AUD_DACLRCK),
        .i_rst_n        (i_rst_n),
        .i_state        (state),
        .i_time         (time_now),
        .i_replay       (i_replay),
        .i_replay_start (replay_start),
        .i_count        (o_event_count),
        .wb             (wb_bus.master),
        .o_toggle       (toggle),
        .o_toggle_voice (toggle_voice)
    );

    tone_voices #(.VOICE_AMPLITUDE(VOICE_AMPLITUDE)) u_voices (
        .i_AUD_DACLRCK  (i_AUD_DACLRCK),
        .i_rst_n        (i_rst_n),
        .i_state        (state),
        .i_time         (time_now),
        .i_key          (live_key),
        .i_toggle       (toggle),
        .i_toggle_voice (toggle_voice),
        .o_enables      (voice_en),
        .o_sample       (o_dac_sample)
    );

endmodule

`default_nettype wire

/* tone_voices.sv */
//--------------------------------------------------------------------------
// eight square-wave voices: enable flags, per-voice phase counters that
// track the sample timer, and the registered output mixer
//--------------------------------------------------------------------------
`default_nettype none

module tone_voices #(
    parameter int VOICE_AMPLITUDE = 600
) (
    input  logic                            i_AUD_DACLRCK,
    input  logic                            i_rst_n,
    input  tone_pkg::ctrl_state_e           i_state,
    input  tone_pkg::stamp_t                i_time,
    input  logic [tone_pkg::NUM_VOICES-1:0] i_key,
    input  logic                            i_toggle,
    input  tone_pkg::voice_t                i_toggle_voice,
    output logic [tone_pkg::NUM_VOICES-1:0] o_enables,
    output tone_pkg::sample_t               o_sample
);
    import tone_pkg::*;

    logic [7:0]            cnt_r   [NUM_VOICES];  // position inside half-period
    logic [7:0]            cnt_cur [NUM_VOICES];
    logic [NUM_VOICES-1:0] ph_r;
    logic [NUM_VOICES-1:0] ph_cur;                // phase for the current time
    logic [NUM_VOICES-1:0] flip;
    logic                  lsb_q;                 // timer lsb the counters saw
    sample_t               mix;

    // ----------------------------------------------------------------------
    // phase tracking
    // ----------------------------------------------------------------------
    // the timer only ever steps by one, holds, or drops to zero, so the
    // counters follow it without a divider
    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            cnt_cur[v] = cnt_r[v];
            ph_cur[v]  = ph_r[v];
            if (i_time == '0) begin
                cnt_cur[v] = '0;
                ph_cur[v]  = 1'b0;
            end else if (i_time[0] != lsb_q) begin
                if (cnt_r[v] == VOICE_HALF_PERIOD[v] - 8'd1) begin
                    cnt_cur[v] = '0;
                    ph_cur[v]  = ~ph_r[v];        // half-period boundary
                end else begin
                    cnt_cur[v] = cnt_r[v] + 8'd1;
                end
            end
        end
    end

    // live key or replayed toggle flips a voice
    always_comb begin
        for (int v = 0; v < NUM_VOICES; v++) begin
            flip[v] = i_key[v] || (i_toggle && (i_toggle_voice == voice_t'(v)));
        end
    end

    // ----------------------------------------------------------------------
    // mixer
    // ----------------------------------------------------------------------
    always_comb begin
        mix = '0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            if (o_enables[v] && ph_cur[v]) begin
                mix = mix + sample_t'(VOICE_AMPLITUDE);
            end
        end
        if (i_state != S_PLAY) begin
            mix = '0;                             // silent outside play
        end
    end

    always_ff @(posedge i_AUD_DACLRCK or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_enables <= '0;
            o_sample  <= '0;
            ph_r      <= '0;
            lsb_q     <= 1'b0;
            for (int v = 0; v < NUM_VOICES; v++) begin
                cnt_r[v] <= '0;
            end
        end else begin
            o_enables <= o_enables ^ flip;
            o_sample  <= mix;
            ph_r      <= ph_cur;
            lsb_q     <= i_time[0];
            for (int v = 0; v < NUM_VOICES; v++) begin
                cnt_r[v] <= cnt_cur[v];
            end
        end
    end

endmodule

`default_nettype wire
